//--- alu/alu.sv
module alu (
	input  logic              enable_execute,
	input  isa_pkg::word_t    alu_src1,
	input  isa_pkg::word_t    alu_src2,
	input  isa_pkg::opcode_t  opcode,
	input  isa_pkg::sub_op_t  sub_op_base,
	output isa_pkg::word_t    alu_result,
	output logic              alu_overflow
);

	// adder split at bit 31 so the two carries around the msb are visible
	// returns {overflow, sum}
	function automatic logic [32:0] add_ovf(
		input isa_pkg::word_t x,
		input isa_pkg::word_t y,
		input logic           cin
	);
		logic [31:0] lo;
		logic [1:0]  hi;
		lo = {1'b0, x[30:0]} + {1'b0, y[30:0]} + {31'b0, cin};
		hi = {1'b0, x[31]} + {1'b0, y[31]} + {1'b0, lo[31]};
		return {lo[31] ^ hi[1], hi[0], lo[30:0]};
	endfunction

	logic [4:0]  shamt;
	logic [63:0] rotate;
	logic [32:0] sum;
	logic [32:0] diff;

	assign shamt = alu_src2[4:0];
	assign rotate = {alu_src1, alu_src1} >> shamt;
	assign sum = add_ovf(alu_src1, alu_src2, 1'b0);
	assign diff = add_ovf(alu_src1, ~alu_src2, 1'b1); // a + ~b + 1

	always_comb begin
		alu_result = '0;
		alu_overflow = 1'b0;
		if (enable_execute) begin
			case (opcode)
				isa_pkg::OP_BASE: begin
					case (sub_op_base)
						isa_pkg::SUB_ADD: begin
							alu_result = sum[31:0];
							alu_overflow = sum[32];
						end
						isa_pkg::SUB_SUB: begin
							alu_result = diff[31:0];
							alu_overflow = diff[32];
						end
						isa_pkg::SUB_AND: alu_result = alu_src1 & alu_src2;
						isa_pkg::SUB_OR: alu_result = alu_src1 | alu_src2;
						isa_pkg::SUB_XOR: alu_result = alu_src1 ^ alu_src2;
						isa_pkg::SUB_SLLI: alu_result = alu_src1 << shamt;
						isa_pkg::SUB_SRLI: alu_result = alu_src1 >> shamt;
						isa_pkg::SUB_ROTRI: alu_result = rotate[31:0];
						default: begin
							alu_result = '0; // unknown sub-op
						end
					endcase
				end
				isa_pkg::OP_ADDI: begin
					alu_result = sum[31:0];
					alu_overflow = sum[32];
				end
				isa_pkg::OP_ORI: alu_result = alu_src1 | alu_src2;
				isa_pkg::OP_XORI: alu_result = alu_src1 ^ alu_src2;
				// address generation
				isa_pkg::OP_LWI,
				isa_pkg::OP_SWI,
				isa_pkg::OP_LS: begin
					alu_result = sum[31:0];
					alu_overflow = sum[32];
				end
				default: begin
					alu_result = '0;
					alu_overflow = 1'b0;
				end
			endcase
		end
	end

endmodule

//--- common/isa_pkg.sv
package isa_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [4:0]  sub_op_t;

	localparam int REG_COUNT = 32; // default register file depth

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// major opcodes, instr[30:25]
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam opcode_t OP_BASE = 6'b100000;
	localparam opcode_t OP_ADDI = 6'b101000;
	localparam opcode_t OP_ORI  = 6'b101100;
	localparam opcode_t OP_XORI = 6'b101011;
	localparam opcode_t OP_LWI  = 6'b000010;
	localparam opcode_t OP_SWI  = 6'b001010;
	localparam opcode_t OP_LS   = 6'b011100; // register indexed load/store

	// base group sub-opcodes, instr[4:0]
	localparam sub_op_t SUB_ADD   = 5'b00000;
	localparam sub_op_t SUB_SUB   = 5'b00001;
	localparam sub_op_t SUB_AND   = 5'b00010;
	localparam sub_op_t SUB_XOR   = 5'b00011;
	localparam sub_op_t SUB_OR    = 5'b00100;
	localparam sub_op_t SUB_SLLI  = 5'b01000;
	localparam sub_op_t SUB_SRLI  = 5'b01001;
	localparam sub_op_t SUB_ROTRI = 5'b01011;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// field positions
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int OPC_MSB = 30;
	localparam int OPC_LSB = 25;
	localparam int RT_MSB  = 24;
	localparam int RT_LSB  = 20;
	localparam int RA_MSB  = 19;
	localparam int RA_LSB  = 15;
	localparam int RB_MSB  = 14; // also the 5-bit shift amount
	localparam int RB_LSB  = 10;
	localparam int IMM_MSB = 14;
	localparam int IMM_LSB = 0;
	localparam int SUB_MSB = 4;
	localparam int SUB_LSB = 0;

	localparam int LS_STORE_BIT = 5; // TY_LS: 1 = store, 0 = load

endpackage

//--- list.f
common/isa_pkg.sv
alu/alu.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/operand_stage.sv
logic/result_stage.sv
logic/exec_core.sv
verification/exec_core_asserts.sv
verification/exec_core_tb.sv

//--- logic/exec_core.sv
module exec_core #(
	parameter int reg_count = isa_pkg::REG_COUNT
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           instr_valid,
	input  isa_pkg::word_t instr,
	output logic           result_valid,
	output isa_pkg::word_t result,
	output logic           overflow,
	output logic           mem_req,
	output logic           mem_write,
	output isa_pkg::word_t mem_addr,
	output isa_pkg::word_t mem_wdata
);

	// decode
	isa_pkg::opcode_t  opcode;
	isa_pkg::sub_op_t  sub_op;
	isa_pkg::reg_idx_t rt, ra, rb;
	isa_pkg::word_t    imm;
	logic              use_imm, writes_rt, is_mem, is_store;

	// register file
	isa_pkg::word_t    rd_data_a, rd_data_b, rd_data_c;
	logic              wr_en;
	isa_pkg::reg_idx_t wr_idx;
	isa_pkg::word_t    wr_data;

	// operand stage / alu
	logic              stage_valid;
	isa_pkg::word_t    src1, src2, store_data;
	isa_pkg::opcode_t  opcode_q;
	isa_pkg::sub_op_t  sub_op_q;
	isa_pkg::reg_idx_t dest_q;
	logic              writes_rt_q, is_mem_q, is_store_q;
	isa_pkg::word_t    alu_result;
	logic              alu_overflow;

	instr_decode u_instr_decode (
		.instr(instr), .opcode(opcode), .sub_op(sub_op),
		.rt(rt), .ra(ra), .rb(rb), .imm(imm),
		.use_imm(use_imm), .writes_rt(writes_rt), .is_mem(is_mem), .is_store(is_store)
	);

	reg_file #(.reg_count(reg_count)) u_reg_file (
		.clk(clk), .reset(reset),
		.rd_idx_a(ra), .rd_idx_b(rb), .rd_idx_c(rt),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .rd_data_c(rd_data_c),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
	);

	operand_stage u_operand_stage (
		.clk(clk), .reset(reset), .instr_valid(instr_valid),
		.opcode(opcode), .sub_op(sub_op), .rt(rt), .ra(ra), .rb(rb), .imm(imm),
		.use_imm(use_imm), .writes_rt(writes_rt), .is_mem(is_mem), .is_store(is_store),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .rd_data_c(rd_data_c),
		.fwd_data(alu_result), // result of the instruction one ahead
		.stage_valid(stage_valid), .src1(src1), .src2(src2), .store_data(store_data),
		.opcode_q(opcode_q), .sub_op_q(sub_op_q), .dest_q(dest_q),
		.writes_rt_q(writes_rt_q), .is_mem_q(is_mem_q), .is_store_q(is_store_q)
	);

	alu u_alu (
		.enable_execute(stage_valid), .alu_src1(src1), .alu_src2(src2),
		.opcode(opcode_q), .sub_op_base(sub_op_q),
		.alu_result(alu_result), .alu_overflow(alu_overflow)
	);

	result_stage u_result_stage (
		.clk(clk), .reset(reset), .stage_valid(stage_valid),
		.writes_rt_q(writes_rt_q), .is_mem_q(is_mem_q), .is_store_q(is_store_q),
		.dest_q(dest_q), .alu_result(alu_result), .alu_overflow(alu_overflow),
		.store_data(store_data),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
		.result_valid(result_valid), .result(result), .overflow(overflow),
		.mem_req(mem_req), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

endmodule

//--- logic/instr_decode.sv
module instr_decode (
	input  isa_pkg::word_t    instr,
	output isa_pkg::opcode_t  opcode,
	output isa_pkg::sub_op_t  sub_op,
	output isa_pkg::reg_idx_t rt,
	output isa_pkg::reg_idx_t ra,
	output isa_pkg::reg_idx_t rb,
	output isa_pkg::word_t    imm,
	output logic              use_imm,
	output logic              writes_rt,
	output logic              is_mem,
	output logic              is_store
);

	logic [14:0] imm15;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// field extraction
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign opcode = instr[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB];
	assign sub_op = instr[isa_pkg::SUB_MSB:isa_pkg::SUB_LSB];
	assign rt = instr[isa_pkg::RT_MSB:isa_pkg::RT_LSB];
	assign ra = instr[isa_pkg::RA_MSB:isa_pkg::RA_LSB];
	assign rb = instr[isa_pkg::RB_MSB:isa_pkg::RB_LSB];
	assign imm15 = instr[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB];

	always_comb begin
		imm = '0;
		use_imm = 1'b0;
		writes_rt = 1'b0;
		is_mem = 1'b0;
		is_store = 1'b0;
		case (opcode)
			isa_pkg::OP_BASE: begin
				writes_rt = 1'b1;
				imm = {27'b0, rb}; // shift amount, only used by shift sub-ops
			end
			isa_pkg::OP_ADDI: begin
				use_imm = 1'b1;
				writes_rt = 1'b1;
				imm = {{17{imm15[14]}}, imm15};
			end
			isa_pkg::OP_ORI,
			isa_pkg::OP_XORI: begin
				use_imm = 1'b1;
				writes_rt = 1'b1;
				imm = {17'b0, imm15}; // logic ops zero extend
			end
			isa_pkg::OP_LWI: begin
				use_imm = 1'b1;
				is_mem = 1'b1;
				imm = {{15{imm15[14]}}, imm15, 2'b00}; // word offset
			end
			isa_pkg::OP_SWI: begin
				use_imm = 1'b1;
				is_mem = 1'b1;
				is_store = 1'b1;
				imm = {{15{imm15[14]}}, imm15, 2'b00};
			end
			isa_pkg::OP_LS: begin
				is_mem = 1'b1; // address is ra + rb
				is_store = instr[isa_pkg::LS_STORE_BIT];
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

//--- logic/operand_stage.sv
module operand_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              instr_valid,
	input  isa_pkg::opcode_t  opcode,
	input  isa_pkg::sub_op_t  sub_op,
	input  isa_pkg::reg_idx_t rt,
	input  isa_pkg::reg_idx_t ra,
	input  isa_pkg::reg_idx_t rb,
	input  isa_pkg::word_t    imm,
	input  logic              use_imm,
	input  logic              writes_rt,
	input  logic              is_mem,
	input  logic              is_store,
	input  isa_pkg::word_t    rd_data_a,
	input  isa_pkg::word_t    rd_data_b,
	input  isa_pkg::word_t    rd_data_c,
	input  isa_pkg::word_t    fwd_data,
	output logic              stage_valid,
	output isa_pkg::word_t    src1,
	output isa_pkg::word_t    src2,
	output isa_pkg::word_t    store_data,
	output isa_pkg::opcode_t  opcode_q,
	output isa_pkg::sub_op_t  sub_op_q,
	output isa_pkg::reg_idx_t dest_q,
	output logic              writes_rt_q,
	output logic              is_mem_q,
	output logic              is_store_q
);

	logic           fwd_live;
	logic           is_shift;
	isa_pkg::word_t val_a, val_b, val_c;

	// instruction held here is still in the alu, so its result is not in the file yet
	assign fwd_live = stage_valid & writes_rt_q;
	assign val_a = (fwd_live && dest_q == ra) ? fwd_data : rd_data_a;
	assign val_b = (fwd_live && dest_q == rb) ? fwd_data : rd_data_b;
	assign val_c = (fwd_live && dest_q == rt) ? fwd_data : rd_data_c;

	assign is_shift = (opcode == isa_pkg::OP_BASE) &&
		(sub_op == isa_pkg::SUB_SLLI || sub_op == isa_pkg::SUB_SRLI ||
		sub_op == isa_pkg::SUB_ROTRI);

	always_ff @(posedge clk) begin
		if (reset) begin
			stage_valid <= 1'b0;
			src1 <= '0;
			src2 <= '0;
			store_data <= '0;
			opcode_q <= '0;
			sub_op_q <= '0;
			dest_q <= '0;
			writes_rt_q <= 1'b0;
			is_mem_q <= 1'b0;
			is_store_q <= 1'b0;
		end
		else begin
			stage_valid <= instr_valid;
			if (instr_valid) begin
				src1 <= val_a;
				src2 <= (use_imm || is_shift) ? imm : val_b;
				store_data <= val_c;
				opcode_q <= opcode;
				sub_op_q <= sub_op;
				dest_q <= rt;
				writes_rt_q <= writes_rt;
				is_mem_q <= is_mem;
				is_store_q <= is_store;
			end
		end
	end

endmodule

//--- logic/reg_file.sv
module reg_file #(
	parameter int reg_count = isa_pkg::REG_COUNT
) (
	input  logic              clk,
	input  logic              reset,
	input  isa_pkg::reg_idx_t rd_idx_a,
	input  isa_pkg::reg_idx_t rd_idx_b,
	input  isa_pkg::reg_idx_t rd_idx_c,
	output isa_pkg::word_t    rd_data_a,
	output isa_pkg::word_t    rd_data_b,
	output isa_pkg::word_t    rd_data_c,
	input  logic              wr_en,
	input  isa_pkg::reg_idx_t wr_idx,
	input  isa_pkg::word_t    wr_data
);

	localparam int idx_w = $clog2(reg_count);

	isa_pkg::word_t regs [reg_count];

	// write-through, a read in the write cycle sees the new value
	function automatic isa_pkg::word_t read_port(input isa_pkg::reg_idx_t idx);
		if (wr_en && (wr_idx == idx))
			return wr_data;
		return regs[idx[idx_w-1:0]];
	endfunction

	always_comb begin
		rd_data_a = read_port(rd_idx_a);
		rd_data_b = read_port(rd_idx_b);
		rd_data_c = read_port(rd_idx_c); // rt, store data
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end
		else if (wr_en) begin
			regs[wr_idx[idx_w-1:0]] <= wr_data;
		end
	end

endmodule

//--- logic/result_stage.sv
module result_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              stage_valid,
	input  logic              writes_rt_q,
	input  logic              is_mem_q,
	input  logic              is_store_q,
	input  isa_pkg::reg_idx_t dest_q,
	input  isa_pkg::word_t    alu_result,
	input  logic              alu_overflow,
	input  isa_pkg::word_t    store_data,
	output logic              wr_en,
	output isa_pkg::reg_idx_t wr_idx,
	output isa_pkg::word_t    wr_data,
	output logic              result_valid,
	output isa_pkg::word_t    result,
	output logic              overflow,
	output logic              mem_req,
	output logic              mem_write,
	output isa_pkg::word_t    mem_addr,
	output isa_pkg::word_t    mem_wdata
);

	logic do_wb, do_mem;

	assign do_wb = stage_valid & writes_rt_q;
	assign do_mem = stage_valid & is_mem_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			wr_idx <= '0;
			result <= '0;
			overflow <= 1'b0;
			mem_req <= 1'b0;
			mem_write <= 1'b0;
			mem_addr <= '0;
			mem_wdata <= '0;
		end
		else begin
			result_valid <= do_wb;
			mem_req <= do_mem;
			mem_write <= do_mem & is_store_q;
			if (do_wb) begin
				wr_idx <= dest_q;
				result <= alu_result;
				overflow <= alu_overflow;
			end
			else begin
				overflow <= 1'b0; // only reported alongside a result
			end
			if (do_mem)
				mem_addr <= alu_result;
			if (do_mem && is_store_q)
				mem_wdata <= store_data;
		end
	end

	assign wr_en = result_valid;
	assign wr_data = result;

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module exec_core_tb -o exec_core_sim

out=$(./obj_dir/exec_core_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF -- '*** TEST PASSED ***'; then
	exit 0
fi
exit 1

//--- verification/exec_core_asserts.sv
module exec_core_asserts (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input logic result_valid,
	input logic overflow,
	input logic mem_req,
	input logic mem_write
);

	// one output pulse per strobe, two edges later
	a_latency: assert property (@(posedge clk) disable iff (reset)
		(result_valid || mem_req) == $past(instr_valid, 2))
		else $error("output pulse does not line up with a strobe two cycles earlier");

	a_one_kind: assert property (@(posedge clk) disable iff (reset)
		!(result_valid && mem_req))
		else $error("result and memory request in the same cycle");

	a_write_in_req: assert property (@(posedge clk) disable iff (reset)
		mem_write |-> mem_req)
		else $error("mem_write high without mem_req");

	a_ovf_with_result: assert property (@(posedge clk) disable iff (reset)
		overflow |-> result_valid)
		else $error("overflow high without result_valid");

endmodule

bind exec_core exec_core_asserts u_exec_core_asserts (
	.clk(clk), .reset(reset), .instr_valid(instr_valid),
	.result_valid(result_valid), .overflow(overflow),
	.mem_req(mem_req), .mem_write(mem_write)
);

//--- verification/exec_core_tb.sv
module exec_core_tb;

	localparam int RESULT = 0;
	localparam int LOAD = 1;
	localparam int STORE = 2;
	localparam int MAX_ENTRIES = 64;

	logic           clk;
	logic           reset;
	logic           instr_valid;
	isa_pkg::word_t instr;
	logic           result_valid, overflow, mem_req, mem_write;
	isa_pkg::word_t result, mem_addr, mem_wdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	isa_pkg::word_t tbl_instr [MAX_ENTRIES];
	int             tbl_gap [MAX_ENTRIES];   // idle cycles after the entry
	int             tbl_kind [MAX_ENTRIES];
	isa_pkg::word_t tbl_value [MAX_ENTRIES]; // result, or address for a memory request
	logic           tbl_ovf [MAX_ENTRIES];
	isa_pkg::word_t tbl_wdata [MAX_ENTRIES];
	int             n_entries = 0;

	int   exp_due [$]; // cycle in which the output pulse shows
	int   exp_idx [$];
	int   cycle_cnt = 0;
	int   timeout_limit = 0;
	int   seed = 78;
	logic reset_checked = 1'b0;

	exec_core #(.reg_count(isa_pkg::REG_COUNT)) u_exec_core (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.result_valid(result_valid), .result(result), .overflow(overflow),
		.mem_req(mem_req), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > timeout_limit)
			fail_run($sformatf("timeout: run exceeded %0d cycles", timeout_limit));
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic word_check(input string name, input isa_pkg::word_t got,
		input isa_pkg::word_t exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch at time %0t: %s = %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic flag_check(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch at time %0t: %s = %b, expected %b",
				$time, name, got, exp));
	endtask

	task automatic mem_req_check(input logic store, input isa_pkg::word_t addr,
		input isa_pkg::word_t wdata);
		flag_check("mem_req", mem_req, 1'b1);
		flag_check("mem_write", mem_write, store);
		word_check("mem_addr", mem_addr, addr);
		if (store)
			word_check("mem_wdata", mem_wdata, wdata);
	endtask

	function automatic isa_pkg::word_t base_instr(input isa_pkg::sub_op_t sub, input int rt,
		input int ra, input int rb);
		return {1'b0, isa_pkg::OP_BASE, isa_pkg::reg_idx_t'(rt), isa_pkg::reg_idx_t'(ra),
			isa_pkg::reg_idx_t'(rb), 5'b0, sub};
	endfunction

	function automatic isa_pkg::word_t imm_instr(input isa_pkg::opcode_t op, input int rt,
		input int ra, input int imm15);
		return {1'b0, op, isa_pkg::reg_idx_t'(rt), isa_pkg::reg_idx_t'(ra), 15'(imm15)};
	endfunction

	function automatic isa_pkg::word_t ls_instr(input logic store, input int rt, input int ra,
		input int rb);
		return {1'b0, isa_pkg::OP_LS, isa_pkg::reg_idx_t'(rt), isa_pkg::reg_idx_t'(ra),
			isa_pkg::reg_idx_t'(rb), 4'b0, store, 5'b0};
	endfunction

	task automatic add_entry(input isa_pkg::word_t ins, input int gap, input int kind,
		input isa_pkg::word_t value, input int ovf, input isa_pkg::word_t wdata);
		tbl_instr[n_entries] = ins;
		tbl_gap[n_entries] = gap;
		tbl_kind[n_entries] = kind;
		tbl_value[n_entries] = value;
		tbl_ovf[n_entries] = (ovf != 0);
		tbl_wdata[n_entries] = wdata;
		n_entries++;
	endtask

	task automatic build_table();
		// constants into cleared registers
		add_entry(imm_instr(isa_pkg::OP_ADDI, 1, 0, 'h0005), 0, RESULT, 32'h00000005, 0, 0);
		add_entry(imm_instr(isa_pkg::OP_ORI, 2, 0, 'h7fff), 0, RESULT, 32'h00007fff, 0, 0);
		add_entry(imm_instr(isa_pkg::OP_ADDI, 3, 0, 'h7fff), 0, RESULT, 32'hffffffff, 0, 0);
		add_entry(imm_instr(isa_pkg::OP_ADDI, 4, 0, 'h4000), 0, RESULT, 32'hffffc000, 0, 0);
		add_entry(imm_instr(isa_pkg::OP_XORI, 5, 0, 'h1234), 2, RESULT, 32'h00001234, 0, 0);
		// dependent chain back to back
		add_entry(base_instr(isa_pkg::SUB_ADD, 6, 1, 2), 0, RESULT, 32'h00008004, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_SUB, 7, 6, 1), 0, RESULT, 32'h00007fff, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_XOR, 8, 7, 6), 0, RESULT, 32'h0000fffb, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_AND, 9, 8, 5), 0, RESULT, 32'h00001230, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_OR, 10, 9, 4), 2, RESULT, 32'hffffd230, 0, 0);
		// same chain through the register file
		add_entry(base_instr(isa_pkg::SUB_ADD, 11, 1, 2), 1, RESULT, 32'h00008004, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_SUB, 12, 11, 1), 1, RESULT, 32'h00007fff, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_XOR, 13, 12, 11), 1, RESULT, 32'h0000fffb, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_AND, 14, 13, 5), 1, RESULT, 32'h00001230, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_OR, 15, 14, 4), 2, RESULT, 32'hffffd230, 0, 0);
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// signed overflow
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		add_entry(imm_instr(isa_pkg::OP_ADDI, 16, 0, 'h7fff), 0, RESULT, 32'hffffffff, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_SRLI, 17, 16, 1), 0, RESULT, 32'h7fffffff, 0, 0);
		add_entry(imm_instr(isa_pkg::OP_ADDI, 18, 0, 'h0001), 0, RESULT, 32'h00000001, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_ADD, 19, 17, 18), 0, RESULT, 32'h80000000, 1, 0);
		add_entry(base_instr(isa_pkg::SUB_SUB, 20, 19, 18), 0, RESULT, 32'h7fffffff, 1, 0);
		add_entry(base_instr(isa_pkg::SUB_ADD, 21, 18, 18), 0, RESULT, 32'h00000002, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_SUB, 22, 18, 17), 0, RESULT, 32'h80000002, 0, 0);
		add_entry(imm_instr(isa_pkg::OP_ADDI, 23, 17, 'h0001), 0, RESULT, 32'h80000000, 1, 0);
		add_entry(imm_instr(isa_pkg::OP_ADDI, 25, 17, 'h7fff), 2, RESULT, 32'h7ffffffe, 0, 0);
		// shifts and rotates of 0x80000003
		add_entry(imm_instr(isa_pkg::OP_ORI, 29, 19, 'h0003), 0, RESULT, 32'h80000003, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_SLLI, 30, 29, 0), 0, RESULT, 32'h80000003, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_SLLI, 30, 29, 1), 0, RESULT, 32'h00000006, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_SLLI, 30, 29, 31), 0, RESULT, 32'h80000000, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_SRLI, 30, 29, 0), 0, RESULT, 32'h80000003, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_SRLI, 30, 29, 1), 0, RESULT, 32'h40000001, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_SRLI, 30, 29, 31), 0, RESULT, 32'h00000001, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_ROTRI, 30, 29, 0), 0, RESULT, 32'h80000003, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_ROTRI, 30, 29, 1), 0, RESULT, 32'hc0000001, 0, 0);
		add_entry(base_instr(isa_pkg::SUB_ROTRI, 30, 29, 31), 2, RESULT, 32'h00000007, 0, 0);
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// loads and stores
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		add_entry(imm_instr(isa_pkg::OP_LWI, 2, 9, 'h0004), 0, LOAD, 32'h00001240, 0, 0);
		add_entry(imm_instr(isa_pkg::OP_SWI, 5, 9, 'h7fff), 0, STORE, 32'h0000122c, 0,
			32'h00001234);
		add_entry(ls_instr(1'b0, 3, 9, 1), 0, LOAD, 32'h00001235, 0, 0);
		add_entry(ls_instr(1'b1, 15, 4, 9), 0, STORE, 32'hffffd230, 0, 32'hffffd230);
		add_entry(imm_instr(isa_pkg::OP_ADDI, 6, 0, 'h0077), 0, RESULT, 32'h00000077, 0, 0);
		add_entry(imm_instr(isa_pkg::OP_SWI, 6, 6, 'h0001), 0, STORE, 32'h0000007b, 0,
			32'h00000077);
		// loads left r2, r3 alone
		add_entry(base_instr(isa_pkg::SUB_XOR, 31, 3, 2), 3, RESULT, 32'hffff8000, 0, 0);
	endtask

	task automatic reset_state_check();
		flag_check("result_valid", result_valid, 1'b0);
		word_check("result", result, '0);
		flag_check("overflow", overflow, 1'b0);
		flag_check("mem_req", mem_req, 1'b0);
		flag_check("mem_write", mem_write, 1'b0);
		word_check("mem_addr", mem_addr, '0);
		word_check("mem_wdata", mem_wdata, '0);
	endtask

	task automatic output_check();
		int idx;
		if (exp_due.size() > 0 && exp_due[0] == cycle_cnt) begin
			idx = exp_idx.pop_front();
			void'(exp_due.pop_front());
			if (tbl_kind[idx] == RESULT) begin
				flag_check("result_valid", result_valid, 1'b1);
				flag_check("mem_req", mem_req, 1'b0);
				word_check("result", result, tbl_value[idx]);
				flag_check("overflow", overflow, tbl_ovf[idx]);
			end
			else begin
				flag_check("result_valid", result_valid, 1'b0);
				flag_check("overflow", overflow, 1'b0);
				mem_req_check(tbl_kind[idx] == STORE, tbl_value[idx], tbl_wdata[idx]);
			end
		end
		else begin
			flag_check("result_valid", result_valid, 1'b0); // nothing due this cycle
			flag_check("mem_req", mem_req, 1'b0);
			flag_check("mem_write", mem_write, 1'b0);
			flag_check("overflow", overflow, 1'b0);
		end
	endtask

	task automatic drive_idle();
		instr_valid = 1'b0;
		instr = $random(seed); // junk on the bus must be ignored
	endtask

	always @(negedge clk) begin
		if (!reset) begin
			if (!reset_checked) begin
				reset_state_check();
				reset_checked = 1'b1;
			end
			output_check();
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		build_table();
		timeout_limit = n_entries * 4 + 50;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int i = 0; i < n_entries; i++) begin
			@(posedge clk);
			#2;
			instr_valid = 1'b1;
			instr = tbl_instr[i];
			exp_due.push_back(cycle_cnt + 2); // sampled next edge, reported one later
			exp_idx.push_back(i);
			for (int g = 0; g < tbl_gap[i]; g++) begin
				@(posedge clk);
				#2;
				drive_idle();
			end
		end
		@(posedge clk);
		#2;
		drive_idle();
		while (exp_due.size() > 0)
			@(posedge clk);
		repeat (3) @(posedge clk);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
